/* verilog/memsys_pkg.sv */
/*
 * Sizes of the shared memory subsystem, the write-size codes and the
 * accessor request, memory request and lane command structs
 */
package memsys_pkg;

    // Accessors are the core load/store unit and the cache refill port
    localparam int N_ACCESSORS = 2;
    localparam int ACC_IDX_W   = (N_ACCESSORS > 1) ? $clog2(N_ACCESSORS) : 1;
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 32;

    // 1 KiB split into byte lanes
    localparam int N_LANES   = 4;
    localparam int LANE_W    = DATA_W / N_LANES;
    localparam int OFS_W     = $clog2(N_LANES);
    localparam int MEM_WORDS = 256;

    // Word index taken from address bits 9 to 2
    localparam int WIDX_W = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } wsize_e;

    // Reserved encoding, never legal on a write
    localparam logic [1:0] SIZE_RSVD = 2'd3;

    // One access as seen by the memory side
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              write;
        wsize_e            size;
    } mem_req_t;

    // Command to a single byte lane
    typedef struct packed {
        logic              en;
        logic              we;
        logic [WIDX_W-1:0] widx;
        logic [LANE_W-1:0] wbyte;
    } lane_cmd_t;

    // Request levels and fields of one accessor
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        wsize_e            size;
        logic              rd;
        logic              wr;
    } acc_req_t;

endpackage

/* verilog/byte_lane_ram.sv */
/*
 * One 8-bit memory lane with synchronous write and registered read
 */
`timescale 1ns/1ps

module byte_lane_ram
    import memsys_pkg::*;
(
    input  logic              clk,
    input  lane_cmd_t         lane_cmd_i,
    output logic [LANE_W-1:0] rdata_o
);

    logic [LANE_W-1:0] mem_q [MEM_WORDS];
    logic [LANE_W-1:0] rdata_q;

    // Write or read, one per enabled cycle
    always_ff @(posedge clk)
    begin
        if (lane_cmd_i.en)
        begin
            if (lane_cmd_i.we)
                mem_q[lane_cmd_i.widx] <= lane_cmd_i.wbyte;
            else
                rdata_q <= mem_q[lane_cmd_i.widx];
        end
    end

    // Holds the last read byte between reads
    assign rdata_o = rdata_q;

endmodule

/* verilog/lane_steer.sv */
/*
 * Lane steering for the byte-lane memory
 * Size and offset decode into per-lane enables and replicated write bytes
 */
`timescale 1ns/1ps

module lane_steer
    import memsys_pkg::*;
(
    input  mem_req_t                mem_req_i,
    input  logic                    mem_valid_i,
    output lane_cmd_t [N_LANES-1:0] lane_cmd_o
);

    logic [OFS_W-1:0]   ofs;
    logic [N_LANES-1:0] win;
    logic               aligned;

    // Source byte of the write data for a given lane
    function automatic logic [OFS_W-1:0] src_byte(wsize_e size, int lane);
        case (size)
            SIZE_BYTE: src_byte = '0;
            SIZE_HALF: src_byte = OFS_W'(lane % 2);
            default:   src_byte = OFS_W'(lane);
        endcase
    endfunction

    assign ofs = mem_req_i.addr[OFS_W-1:0];

    // Write window from size and offset
    always_comb
    begin
        case (mem_req_i.size)
            SIZE_BYTE: win = N_LANES'(1) << ofs;
            SIZE_HALF: win = N_LANES'(3) << ofs;
            SIZE_WORD: win = {N_LANES{1'b1}} << ofs;
            default:   win = '0;
        endcase
    end

    always_comb
    begin
        case (mem_req_i.size)
            SIZE_BYTE: aligned = 1'b1;
            SIZE_HALF: aligned = ~ofs[0];
            SIZE_WORD: aligned = (ofs == '0);
            default:   aligned = 1'b0;
        endcase
    end

    // Reads open every lane, writes only the window
    always_comb
    begin
        for (int l = 0; l < N_LANES; l++)
        begin
            lane_cmd_o[l].en    = mem_valid_i & (~mem_req_i.write | win[l]);
            lane_cmd_o[l].we    = mem_valid_i & mem_req_i.write & win[l];
            lane_cmd_o[l].widx  = mem_req_i.addr[OFS_W +: WIDX_W];
            lane_cmd_o[l].wbyte = mem_req_i.wdata[src_byte(mem_req_i.size, l)*LANE_W +: LANE_W];
        end
    end

    // Halfword at an odd offset or word off a word boundary
    always_comb
    begin
        if (mem_valid_i && mem_req_i.write)
            a_window_aligned: assert final (aligned)
                else $error("lane_steer: write window not aligned to its size");
    end

endmodule

/* verilog/read_merge.sv */
/*
 * Read merge for the byte lanes
 * Word assembly from lane bytes and the one-cycle delayed response strobe
 */
`timescale 1ns/1ps

module read_merge
    import memsys_pkg::*;
(
    input  logic                           clk,
    input  logic                           resetn_i,
    input  logic                           issue_i,
    input  logic [N_LANES-1:0][LANE_W-1:0] lane_rdata_i,
    output logic [DATA_W-1:0]              rdata_o,
    output logic                           valid_o
);

    logic valid_q;

    // Lane data is registered in the lanes, so the strobe needs one stage
    always_ff @(posedge clk)
    begin
        if (!resetn_i)
            valid_q <= 1'b0;
        else
            valid_q <= issue_i;
    end

    // Lane 0 is the least significant byte
    always_comb
    begin
        for (int l = 0; l < N_LANES; l++)
            rdata_o[l*LANE_W +: LANE_W] = lane_rdata_i[l];
    end

    assign valid_o = valid_q;

    a_valid_single: assert property (
        @(posedge clk) disable iff (!resetn_i)
        valid_o |=> !valid_o
    ) else $error("read_merge: response strobe high on two consecutive cycles");

endmodule

/* verilog/mem_ctrl.sv */
/*
 * Memory controller for the shared memory
 * Write-first, lowest-index arbitration and a three-state access sequencer
 */
`timescale 1ns/1ps

module mem_ctrl
    import memsys_pkg::*;
(
    input  logic                                clk,
    input  logic                                resetn_i,
    // Accessors
    input  acc_req_t [N_ACCESSORS-1:0]          acc_req_i,
    output logic     [N_ACCESSORS-1:0][DATA_W-1:0] acc_data_o,
    output logic     [N_ACCESSORS-1:0]          acc_done_o,
    // Memory
    output mem_req_t                            mem_req_o,
    output logic                                mem_valid_o,
    input  logic     [DATA_W-1:0]               mem_rdata_i,
    input  logic                                mem_valid_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_e;

    state_e               state_q;
    state_e               state_d;
    logic [ACC_IDX_W-1:0] sel_q;
    logic [ACC_IDX_W-1:0] win_idx;
    logic                 win_any;
    logic                 win_wr;
    mem_req_t             req_q;

    // Readers first, then writers, so any writer overrides a reader.
    // Scanning downwards leaves the lowest index as the winner
    always_comb
    begin
        win_idx = '0;
        win_any = 1'b0;
        win_wr  = 1'b0;
        for (int i = N_ACCESSORS - 1; i >= 0; i--)
        begin
            if (acc_req_i[i].rd)
            begin
                win_idx = ACC_IDX_W'(i);
                win_any = 1'b1;
            end
        end
        for (int i = N_ACCESSORS - 1; i >= 0; i--)
        begin
            if (acc_req_i[i].wr)
            begin
                win_idx = ACC_IDX_W'(i);
                win_any = 1'b1;
                win_wr  = 1'b1;
            end
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (win_any) state_d = ST_ISSUE;
            ST_ISSUE: state_d = ST_WAIT;
            ST_WAIT:  if (mem_valid_i) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn_i)
        begin
            state_q <= ST_IDLE;
            sel_q   <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == ST_IDLE && win_any)
                sel_q <= win_idx;
        end
    end

    // Snapshot of the granted request, held for the whole access
    always_ff @(posedge clk)
    begin
        if (state_q == ST_IDLE && win_any)
        begin
            req_q.addr  <= acc_req_i[win_idx].addr;
            req_q.wdata <= acc_req_i[win_idx].wdata;
            req_q.size  <= acc_req_i[win_idx].size;
            req_q.write <= win_wr;
        end
    end

    assign mem_req_o   = req_q;
    assign mem_valid_o = (state_q == ST_ISSUE);

    // Done and read data only for the latched accessor
    always_comb
    begin
        acc_done_o = '0;
        acc_data_o = '0;
        if (state_q == ST_WAIT && mem_valid_i)
        begin
            acc_done_o[sel_q] = 1'b1;
            if (!req_q.write)
                acc_data_o[sel_q] = mem_rdata_i;
        end
    end

    // Response from the read path must line up with the wait state
    a_valid_in_wait: assert property (
        @(posedge clk) disable iff (!resetn_i)
        mem_valid_i |-> (state_q == ST_WAIT)
    ) else $error("mem_ctrl: memory valid outside the wait state");

    a_no_rsvd_size: assert property (
        @(posedge clk) disable iff (!resetn_i)
        (mem_valid_o && req_q.write) |-> (req_q.size != SIZE_RSVD)
    ) else $error("mem_ctrl: write issued with reserved size");

endmodule

/* verilog/memsys_top.sv */
/*
 * Top level of the shared memory subsystem
 * Controller, lane steering, byte-lane RAMs and read merge
 */
`timescale 1ns/1ps

module memsys_top
    import memsys_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   resetn_i,
    input  acc_req_t [N_ACCESSORS-1:0]             acc_req_i,
    output logic     [N_ACCESSORS-1:0][DATA_W-1:0] acc_data_o,
    output logic     [N_ACCESSORS-1:0]             acc_done_o
);

    mem_req_t                       mem_req;
    logic                           mem_issue;
    lane_cmd_t [N_LANES-1:0]        lane_cmd;
    logic [N_LANES-1:0][LANE_W-1:0] lane_rdata;
    logic [DATA_W-1:0]              mem_rdata;
    logic                           mem_valid;

    mem_ctrl u_mem_ctrl (
        .clk         (clk),
        .resetn_i    (resetn_i),
        .acc_req_i   (acc_req_i),
        .acc_data_o  (acc_data_o),
        .acc_done_o  (acc_done_o),
        .mem_req_o   (mem_req),
        .mem_valid_o (mem_issue),
        .mem_rdata_i (mem_rdata),
        .mem_valid_i (mem_valid)
    );

    lane_steer u_lane_steer (
        .mem_req_i   (mem_req),
        .mem_valid_i (mem_issue),
        .lane_cmd_o  (lane_cmd)
    );

    // One RAM per byte lane
    for (genvar l = 0; l < N_LANES; l++)
    begin : g_lane
        byte_lane_ram u_lane (
            .clk        (clk),
            .lane_cmd_i (lane_cmd[l]),
            .rdata_o    (lane_rdata[l])
        );
    end

    read_merge u_read_merge (
        .clk          (clk),
        .resetn_i     (resetn_i),
        .issue_i      (mem_issue),
        .lane_rdata_i (lane_rdata),
        .rdata_o      (mem_rdata),
        .valid_o      (mem_valid)
    );

endmodule

/* verif/tb_clkgen.sv */
/*
 * Testbench clock and reset source
 * 40 ns clock and an active-low reset held for 3 cycles
 */
`timescale 1ns/1ps

module tb_clkgen
(
    output logic clk,
    output logic resetn_o
);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Release on a falling edge, like every other DUT input
    initial
    begin
        resetn_o = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn_o = 1'b1;
    end

endmodule

/* verif/tb_memsys.sv */
/*
 * Testbench for the shared memory subsystem
 * Accessor stimulus, byte-array reference model, checking assertions,
 * watchdog and final report
 */
`timescale 1ns/1ps

module tb_memsys
    import memsys_pkg::*;
();

    localparam int          MEM_BYTES   = MEM_WORDS * N_LANES;
    localparam int          BADDR_W     = WIDX_W + OFS_W;
    localparam logic [31:0] LFSR_SEED   = 32'hb1cc_6861;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
    localparam int          T6_ACC      = 200;
    // Tests 1 to 5 take 2, 6, 13, 3 and 3 accesses
    localparam int          TOTAL_ACC   = 27 + T6_ACC;
    // 3 cycles per access plus the gap between requests
    localparam int          WATCHDOG_CYC = TOTAL_ACC * (3 + 2) + 100;

    logic                              clk;
    logic                              resetn;
    acc_req_t [N_ACCESSORS-1:0]        acc_req;
    logic [N_ACCESSORS-1:0][DATA_W-1:0] acc_data;
    logic [N_ACCESSORS-1:0]            acc_done;
    logic [N_ACCESSORS-1:0]            lvl;
    logic [N_ACCESSORS-1:0][DATA_W-1:0] exp_data;
    logic [7:0]                        ref_mem [MEM_BYTES];
    logic [31:0]                       lfsr_q;
    logic                              solo;
    logic                              race_on;
    logic                              race_won;
    int                                race_loser;
    int                                err_count;
    int                                n_tests;
    int                                n_failed;
    string                             test_name;

    tb_clkgen u_clkgen (
        .clk      (clk),
        .resetn_o (resetn)
    );

    memsys_top dut (
        .clk        (clk),
        .resetn_i   (resetn),
        .acc_req_i  (acc_req),
        .acc_data_o (acc_data),
        .acc_done_o (acc_done)
    );

    for (genvar i = 0; i < N_ACCESSORS; i++)
    begin : g_lvl
        assign lvl[i] = acc_req[i].rd | acc_req[i].wr;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            v = {v[30:0], lfsr_q[0]};
            if (lfsr_q[0])
                lfsr_q = (lfsr_q >> 1) ^ LFSR_TAPS;
            else
                lfsr_q = lfsr_q >> 1;
        end
        return v;
    endfunction

    function automatic void model_write(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data,
                                        wsize_e size);
        int nbytes;
        nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        for (int k = 0; k < nbytes; k++)
            ref_mem[int'(addr[BADDR_W-1:0]) + k] = data[8*k +: 8];
    endfunction

    // Reads always return the aligned word
    function automatic logic [DATA_W-1:0] model_word(logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] w;
        int                base;
        base = int'({addr[BADDR_W-1:OFS_W], OFS_W'(0)});
        for (int l = 0; l < N_LANES; l++)
            w[8*l +: 8] = ref_mem[base + l];
        return w;
    endfunction

    // One access: raise the level, wait for done, then drop the level
    task automatic run_access(input int idx, input bit wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input wsize_e size);
        @(negedge clk);
        acc_req[idx].addr  = addr;
        acc_req[idx].wdata = data;
        acc_req[idx].size  = size;
        acc_req[idx].wr    = wr;
        acc_req[idx].rd    = !wr;
        do
            @(negedge clk);
        while (!acc_done[idx]);
        if (wr)
        begin
            exp_data[idx] = '0;
            model_write(addr, data, size);
        end
        else
            exp_data[idx] = model_word(addr);
        if (race_on && idx != race_loser)
            race_won = 1'b1;
        acc_req[idx].rd = 1'b0;
        acc_req[idx].wr = 1'b0;
    endtask

    task automatic pick_access(output bit wr, output logic [ADDR_W-1:0] addr,
                               output logic [DATA_W-1:0] data, output wsize_e size);
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] widx;
        logic [1:0]  ofs;
        r    = take_bits(1);
        wr   = r[0];
        r    = take_bits(2);
        size = (r[1:0] == 2'd3) ? SIZE_WORD : wsize_e'(r[1:0]);
        hi   = take_bits(22);
        widx = take_bits(4);
        r    = take_bits((size == SIZE_BYTE) ? 2 : (size == SIZE_HALF) ? 1 : 0);
        ofs  = (size == SIZE_BYTE) ? r[1:0] : (size == SIZE_HALF) ? {r[0], 1'b0} : 2'd0;
        addr = {hi[21:0], 4'b0000, widx[3:0], ofs};
        data = take_bits(32);
    endtask

    task automatic report_test(input int errs_before);
        // Lets the data check of the last done fire first
        @(negedge clk);
        n_tests++;
        if (err_count != errs_before)
            n_failed++;
        $display("test %0d %s finished, %0d errors", n_tests, test_name,
                 err_count - errs_before);
    endtask

    for (genvar i = 0; i < N_ACCESSORS; i++)
    begin : g_chk
        a_data: assert property (@(posedge clk) disable iff (!resetn)
            acc_done[i] |-> acc_data[i] === exp_data[i])
        else
        begin
            $display("ERR %s acc%0d expected %h actual %h", test_name, i,
                     $sampled(exp_data[i]), $sampled(acc_data[i]));
            err_count = err_count + 1;
        end

        a_idle_zero: assert property (@(negedge clk) disable iff (!resetn)
            !acc_done[i] |-> acc_data[i] == '0)
        else
        begin
            $display("ERR %s acc%0d output outside done expected %h actual %h", test_name,
                     i, {DATA_W{1'b0}}, $sampled(acc_data[i]));
            err_count = err_count + 1;
        end

        a_done_lvl: assert property (@(negedge clk) disable iff (!resetn)
            acc_done[i] |-> lvl[i])
        else
        begin
            $display("%s: acc%0d got done without a pending request", test_name, i);
            err_count = err_count + 1;
        end

        a_latency: assert property (@(negedge clk) disable iff (!resetn)
            (solo && $rose(lvl[i])) |-> !acc_done[i] ##1 acc_done[i])
        else
        begin
            $display("%s: acc%0d done not in the second cycle after its request",
                     test_name, i);
            err_count = err_count + 1;
        end
    end

    a_one_done: assert property (@(negedge clk) disable iff (!resetn) $onehot0(acc_done))
    else
    begin
        $display("%s: more than one done bit high in a cycle", test_name);
        err_count = err_count + 1;
    end

    a_order: assert property (@(negedge clk) disable iff (!resetn)
        (race_on && acc_done[race_loser]) |-> race_won)
    else
    begin
        $display("%s: acc%0d finished before the access that has priority", test_name,
                 race_loser);
        err_count = err_count + 1;
    end

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired in %s, an access never finished", test_name);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        bit                wr [N_ACCESSORS];
        logic [ADDR_W-1:0] addr [N_ACCESSORS];
        logic [DATA_W-1:0] data [N_ACCESSORS];
        wsize_e            size [N_ACCESSORS];
        logic [31:0]       pick;
        int                errs;
        int                n_acc;
        acc_req    = '0;
        exp_data   = '0;
        lfsr_q     = LFSR_SEED;
        solo       = 1'b1;
        race_on    = 1'b0;
        race_won   = 1'b0;
        race_loser = 0;
        err_count  = 0;
        n_tests    = 0;
        n_failed   = 0;
        test_name  = "reset";
        @(posedge resetn);

        // Quiet period checks done and outputs after reset
        errs = err_count;
        test_name = "reset_and_latency";
        repeat (4) @(negedge clk);
        run_access(0, 1'b1, 32'h0000_0004, 32'hcafe_f00d, SIZE_WORD);
        run_access(1, 1'b0, 32'h0000_0004, '0, SIZE_WORD);
        report_test(errs);

        errs = err_count;
        test_name = "word_write_read";
        run_access(0, 1'b1, 32'h0000_0100, 32'h1234_5678, SIZE_WORD);
        run_access(1, 1'b0, 32'h0000_0100, '0, SIZE_WORD);
        run_access(1, 1'b1, 32'h0000_03fc, 32'h8765_4321, SIZE_WORD);
        run_access(0, 1'b0, 32'h0000_03fc, '0, SIZE_WORD);
        // High address bits are ignored by the memory
        run_access(0, 1'b1, 32'habcd_0010, 32'h0f1e_2d3c, SIZE_WORD);
        run_access(1, 1'b0, 32'h0000_0010, '0, SIZE_WORD);
        report_test(errs);

        errs = err_count;
        test_name = "partial_writes";
        run_access(0, 1'b1, 32'h0000_0020, 32'h1122_3344, SIZE_WORD);
        for (int o = 0; o < N_LANES; o++)
        begin
            run_access(0, 1'b1, 32'h0000_0020 + o, take_bits(32), SIZE_BYTE);
            run_access(1, 1'b0, 32'h0000_0020, '0, SIZE_WORD);
        end
        for (int o = 0; o < N_LANES; o += 2)
        begin
            run_access(1, 1'b1, 32'h0000_0020 + o, take_bits(32), SIZE_HALF);
            run_access(0, 1'b0, 32'h0000_0020, '0, SIZE_WORD);
        end
        report_test(errs);

        errs = err_count;
        test_name = "read_write_race";
        run_access(0, 1'b1, 32'h0000_0080, 32'haaaa_5555, SIZE_WORD);
        solo       = 1'b0;
        race_on    = 1'b1;
        race_won   = 1'b0;
        race_loser = 0;
        fork
            run_access(0, 1'b0, 32'h0000_0080, '0, SIZE_WORD);
            run_access(1, 1'b1, 32'h0000_0080, 32'h5a5a_a5a5, SIZE_WORD);
        join
        race_on = 1'b0;
        report_test(errs);

        errs = err_count;
        test_name = "write_write_race";
        race_on    = 1'b1;
        race_won   = 1'b0;
        race_loser = 1;
        fork
            run_access(0, 1'b1, 32'h0000_0090, 32'h0000_1111, SIZE_WORD);
            run_access(1, 1'b1, 32'h0000_0090, 32'h2222_0000, SIZE_WORD);
        join
        race_on = 1'b0;
        solo    = 1'b1;
        run_access(0, 1'b0, 32'h0000_0090, '0, SIZE_WORD);
        report_test(errs);

        errs = err_count;
        test_name = "random_traffic";
        solo  = 1'b0;
        n_acc = 0;
        while (n_acc < T6_ACC)
        begin
            pick = take_bits(2);
            if (pick[1] && n_acc + 2 <= T6_ACC)
            begin
                pick_access(wr[0], addr[0], data[0], size[0]);
                pick_access(wr[1], addr[1], data[1], size[1]);
                fork
                    run_access(0, wr[0], addr[0], data[0], size[0]);
                    run_access(1, wr[1], addr[1], data[1], size[1]);
                join
                n_acc += 2;
            end
            else
            begin
                pick_access(wr[0], addr[0], data[0], size[0]);
                run_access(int'(pick[0]), wr[0], addr[0], data[0], size[0]);
                n_acc += 1;
            end
        end
        report_test(errs);

        $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, err_count);
        if (err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* tb.f */
verilog/memsys_pkg.sv
verilog/byte_lane_ram.sv
verilog/lane_steer.sv
verilog/read_merge.sv
verilog/mem_ctrl.sv
verilog/memsys_top.sv
verif/tb_clkgen.sv
verif/tb_memsys.sv

/* Bender.yml */
package:
  name: memsys

sources:
  # Design
  - files:
      - verilog/memsys_pkg.sv
      - verilog/byte_lane_ram.sv
      - verilog/lane_steer.sv
      - verilog/read_merge.sv
      - verilog/mem_ctrl.sv
      - verilog/memsys_top.sv

  # Testbench
  - target: simulation
    files:
      - verif/tb_clkgen.sv
      - verif/tb_memsys.sv
